// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_rv_core
RTL_TOP   := rv_core
FILELIST  := sources.f
BUILD_DIR := obj_dir
LOG       := sim.log

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "=== PASS ===" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: common/rv_core_pkg.sv
// shared encodings for the single-cycle rv32i core
// only word loads/stores and beq/bne branches are decoded
`default_nettype none

package rv_core_pkg;

    localparam int XLEN = 32;
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // major opcodes
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    // funct3 for alu ops and branches
    localparam logic [2:0] F3_ADD  = 3'b000;   // add/sub
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;   // srl/sra
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;

    // alu operation codes
    localparam logic [3:0] ALU_ADD  = 4'd0;
    localparam logic [3:0] ALU_SUB  = 4'd1;
    localparam logic [3:0] ALU_AND  = 4'd2;
    localparam logic [3:0] ALU_OR   = 4'd3;
    localparam logic [3:0] ALU_XOR  = 4'd4;
    localparam logic [3:0] ALU_SLL  = 4'd5;
    localparam logic [3:0] ALU_SRL  = 4'd6;
    localparam logic [3:0] ALU_SRA  = 4'd7;
    localparam logic [3:0] ALU_SLT  = 4'd8;
    localparam logic [3:0] ALU_SLTU = 4'd9;

    // immediate formats
    localparam logic [2:0] IMM_I = 3'd0;
    localparam logic [2:0] IMM_S = 3'd1;
    localparam logic [2:0] IMM_B = 3'd2;
    localparam logic [2:0] IMM_U = 3'd3;
    localparam logic [2:0] IMM_J = 3'd4;

    localparam logic [1:0] SRCA_RS1  = 2'd0;
    localparam logic [1:0] SRCA_PC   = 2'd1;
    localparam logic [1:0] SRCA_ZERO = 2'd2;   // lui passes the immediate through

    localparam logic SRCB_RS2 = 1'b0;
    localparam logic SRCB_IMM = 1'b1;

    // register write-back source
    localparam logic [1:0] RF_ALU  = 2'd0;
    localparam logic [1:0] RF_DMEM = 2'd1;
    localparam logic [1:0] RF_PC4  = 2'd2;

    localparam logic [1:0] BR_NONE = 2'd0;
    localparam logic [1:0] BR_COND = 2'd1;
    localparam logic [1:0] BR_JAL  = 2'd2;
    localparam logic [1:0] BR_JALR = 2'd3;

    // one instruction word, register view and immediate view
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
    } instr_u;

endpackage : rv_core_pkg

`default_nettype wire

// File: control/rv_control_unit.sv
// main decoder, one process per control line
// funct3 of loads and stores is not checked, every access is a word
`timescale 1ns/1ps
`default_nettype none

module rv_control_unit
    import rv_core_pkg::*;
(
    input  logic [6:0] opcode,
    input  logic [2:0] funct3,
    input  logic [6:0] funct7,
    output logic [2:0] imm_sel,
    output logic [1:0] srca_sel,
    output logic       srcb_sel,
    output logic [3:0] alu_code,
    output logic [1:0] branch_kind,
    output logic       branch_neg,
    output logic       we_rf,
    output logic [1:0] rf_src,
    output logic       we_dm
);

    instr_u cw;   // decode fields rebuilt into a word
    logic   alt_op;

    always_comb
    begin
        cw          = '0;
        cw.r.opcode = opcode;
        cw.r.funct3 = funct3;
        cw.r.funct7 = funct7;
    end

    // sub/sra for reg ops, sra only for immediate shifts
    assign alt_op = cw.r.funct7[5];

    assign branch_neg = cw.r.funct3[0];   // bne vs beq
    assign we_dm      = (cw.r.opcode == OP_STORE);

    always_comb
    begin
        imm_sel = IMM_I;
        case (cw.r.opcode)
            OP_STORE:         imm_sel = IMM_S;
            OP_BRANCH:        imm_sel = IMM_B;
            OP_LUI, OP_AUIPC: imm_sel = IMM_U;
            OP_JAL:           imm_sel = IMM_J;
            default:          ;
        endcase
    end

    always_comb
    begin
        srca_sel = SRCA_RS1;
        case (cw.r.opcode)
            OP_LUI:   srca_sel = SRCA_ZERO;
            OP_AUIPC: srca_sel = SRCA_PC;
            default:  ;
        endcase
    end

    always_comb
    begin
        srcb_sel = SRCB_IMM;
        if (cw.r.opcode == OP_REG || cw.r.opcode == OP_BRANCH)
            srcb_sel = SRCB_RS2;
    end

    always_comb
    begin
        alu_code = ALU_ADD;   // address and link math
        if (cw.r.opcode == OP_REG || cw.r.opcode == OP_IMM)
        begin
            case (cw.r.funct3)
                F3_ADD:  alu_code = (cw.r.opcode == OP_REG && alt_op) ? ALU_SUB : ALU_ADD;
                F3_SLL:  alu_code = ALU_SLL;
                F3_SLT:  alu_code = ALU_SLT;
                F3_SLTU: alu_code = ALU_SLTU;
                F3_XOR:  alu_code = ALU_XOR;
                F3_SR:   alu_code = alt_op ? ALU_SRA : ALU_SRL;
                F3_OR:   alu_code = ALU_OR;
                F3_AND:  alu_code = ALU_AND;
                default: ;
            endcase
        end
        else if (cw.r.opcode == OP_BRANCH)
            alu_code = ALU_SUB;
    end

    always_comb
    begin
        branch_kind = BR_NONE;
        case (cw.r.opcode)
            OP_BRANCH:
                if (cw.r.funct3 == F3_BEQ || cw.r.funct3 == F3_BNE)
                    branch_kind = BR_COND;   // blt/bge fall through as nop
            OP_JAL:  branch_kind = BR_JAL;
            OP_JALR: branch_kind = BR_JALR;
            default: ;
        endcase
    end

    always_comb
    begin
        we_rf = 1'b0;
        case (cw.r.opcode)
            OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
            OP_LOAD, OP_IMM, OP_REG: we_rf = 1'b1;
            default:                 ;
        endcase
    end

    always_comb
    begin
        rf_src = RF_ALU;
        case (cw.r.opcode)
            OP_LOAD:         rf_src = RF_DMEM;
            OP_JAL, OP_JALR: rf_src = RF_PC4;
            default:         ;
        endcase
    end

endmodule : rv_control_unit

`default_nettype wire

// File: datapath/rv_alu.sv
// combinational alu, shift amount from b[4:0]
// zero flags a == b independent of the selected operation
`timescale 1ns/1ps
`default_nettype none

module rv_alu
    import rv_core_pkg::*;
(
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  logic [3:0]      alu_code,
    output logic [XLEN-1:0] result,
    output logic            zero
);

    logic [4:0] shamt;

    assign shamt = b[4:0];
    assign zero  = (a == b);   // used by beq/bne

    always_comb
    begin
        case (alu_code)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLL:  result = a << shamt;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt;
            ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: result = {31'b0, a < b};
            default:  result = '0;
        endcase
    end

endmodule : rv_alu

`default_nettype wire

// File: datapath/rv_branch_unit.sv
// next pc selection, only beq/bne as conditional branches
`timescale 1ns/1ps
`default_nettype none

module rv_branch_unit
    import rv_core_pkg::*;
(
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] imm,
    input  logic [XLEN-1:0] alu_result,
    input  logic            zero,
    input  logic [1:0]      branch_kind,
    input  logic            branch_neg,
    output logic [XLEN-1:0] next_pc,
    output logic [XLEN-1:0] pc_plus4
);

    logic [XLEN-1:0] target;

    assign pc_plus4 = pc + 32'd4;
    assign target   = pc + imm;   // branch and jal target

    always_comb
    begin
        case (branch_kind)
            BR_COND: next_pc = (zero != branch_neg) ? target : pc_plus4;
            BR_JAL:  next_pc = target;
            BR_JALR: next_pc = {alu_result[XLEN-1:1], 1'b0};
            default: next_pc = pc_plus4;
        endcase
    end

endmodule : rv_branch_unit

`default_nettype wire

// File: datapath/rv_imm_gen.sv
// sign-extended immediates for i, s, b, u and j formats
`timescale 1ns/1ps
`default_nettype none

module rv_imm_gen
    import rv_core_pkg::*;
(
    input  logic [31:0]     instr,
    input  logic [2:0]      imm_sel,
    output logic [XLEN-1:0] imm
);

    logic sign;

    assign sign = instr[31];

    always_comb
    begin
        case (imm_sel)
            IMM_I: imm = {{20{sign}}, instr[31:20]};
            IMM_S: imm = {{20{sign}}, instr[31:25], instr[11:7]};
            // b and j keep bit 0 clear
            IMM_B: imm = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
            IMM_U: imm = {instr[31:12], 12'b0};
            IMM_J: imm = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

endmodule : rv_imm_gen

`default_nettype wire

// File: datapath/rv_reg_file.sv
// 32 x 32 register file, x0 reads zero and ignores writes
// reads are combinational, so a write shows up one cycle later
`timescale 1ns/1ps
`default_nettype none

module rv_reg_file
    import rv_core_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic [4:0]      ra1,
    input  logic [4:0]      ra2,
    input  logic [4:0]      wa,
    input  logic [XLEN-1:0] wd,
    input  logic            we,
    output logic [XLEN-1:0] rd1,
    output logic [XLEN-1:0] rd2
);

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (we && wa != 5'd0)
            regs[wa] <= wd;
    end

    assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

endmodule : rv_reg_file

`default_nettype wire

// File: sources.f
common/rv_core_pkg.sv
control/rv_control_unit.sv
datapath/rv_alu.sv
datapath/rv_reg_file.sv
datapath/rv_imm_gen.sv
datapath/rv_branch_unit.sv
src/rv_core.sv
verification/tb_rv_core.sv

// File: src/rv_core.sv
// single-cycle rv32i core, one instruction retires per clk edge
// both memories must answer combinationally, there is no stall
// dmem write is taken by the memory on the rising edge while dmem_we is high
`timescale 1ns/1ps
`default_nettype none

module rv_core
    import rv_core_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    output logic [XLEN-1:0] imem_addr,
    input  logic [31:0]     imem_data,
    output logic [XLEN-1:0] dmem_addr,
    output logic [XLEN-1:0] dmem_wdata,
    output logic            dmem_we,
    input  logic [XLEN-1:0] dmem_rdata
);

    instr_u          instr;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] rd1;
    logic [XLEN-1:0] rd2;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] src_a;
    logic [XLEN-1:0] src_b;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] wb_data;
    logic            zero;
    logic [2:0]      imm_sel;
    logic [1:0]      srca_sel;
    logic            srcb_sel;
    logic [3:0]      alu_code;
    logic [1:0]      branch_kind;
    logic            branch_neg;
    logic            we_rf;
    logic [1:0]      rf_src;
    logic            we_dm;

    assign instr     = imem_data;
    assign imem_addr = pc;

    always_ff @(posedge clk)
    begin
        if (rst)
            pc <= RESET_PC;
        else
            pc <= next_pc;
    end

    rv_control_unit control_unit_inst (
        .opcode      (instr.r.opcode),
        .funct3      (instr.r.funct3),
        .funct7      (instr.r.funct7),
        .imm_sel     (imm_sel),
        .srca_sel    (srca_sel),
        .srcb_sel    (srcb_sel),
        .alu_code    (alu_code),
        .branch_kind (branch_kind),
        .branch_neg  (branch_neg),
        .we_rf       (we_rf),
        .rf_src      (rf_src),
        .we_dm       (we_dm)
    );

    rv_reg_file reg_file_inst (
        .clk (clk),
        .rst (rst),
        .ra1 (instr.r.rs1),
        .ra2 (instr.r.rs2),
        .wa  (instr.r.rd),
        .wd  (wb_data),
        .we  (we_rf & ~rst),   // no writeback while in reset
        .rd1 (rd1),
        .rd2 (rd2)
    );

    rv_imm_gen imm_gen_inst (
        .instr   (instr),
        .imm_sel (imm_sel),
        .imm     (imm)
    );

    always_comb
    begin
        case (srca_sel)
            SRCA_RS1:  src_a = rd1;
            SRCA_PC:   src_a = pc;   // auipc
            SRCA_ZERO: src_a = '0;
            default:   src_a = '0;
        endcase
    end

    assign src_b = (srcb_sel == SRCB_IMM) ? imm : rd2;

    rv_alu alu_inst (
        .a        (src_a),
        .b        (src_b),
        .alu_code (alu_code),
        .result   (alu_result),
        .zero     (zero)
    );

    rv_branch_unit branch_unit_inst (
        .pc          (pc),
        .imm         (imm),
        .alu_result  (alu_result),
        .zero        (zero),
        .branch_kind (branch_kind),
        .branch_neg  (branch_neg),
        .next_pc     (next_pc),
        .pc_plus4    (pc_plus4)
    );

    always_comb
    begin
        case (rf_src)
            RF_DMEM: wb_data = dmem_rdata;
            RF_PC4:  wb_data = pc_plus4;   // jal/jalr link
            default: wb_data = alu_result;
        endcase
    end

    assign dmem_addr  = alu_result;
    assign dmem_wdata = rd2;
    assign dmem_we    = we_dm & ~rst;

endmodule : rv_core

`default_nettype wire

// File: verification/tb_rv_core.sv
// testbench for rv_core, runs a fixed program and checks every data store in order
// instruction and data memories are modeled here, both read combinationally
// program words are encoded from the rv32i formats, expected stores are worked out by hand
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

    localparam int PROG_LEN = 54;
    localparam int N_STORES = 18;
    localparam int TIMEOUT  = PROG_LEN * 4;
    localparam logic [31:0] NOP        = 32'h0000_0013;   // addi x0, x0, 0
    localparam logic [31:0] IMEM_BYTES = 32'(PROG_LEN * 4);
    localparam logic [31:0] PARK_PC    = 32'((PROG_LEN - 1) * 4);   // closing self-jump
    localparam logic [6:0]  OPC_IMM    = 7'b0010011;
    localparam logic [6:0]  OPC_LOAD   = 7'b0000011;
    localparam logic [6:0]  OPC_JALR   = 7'b1100111;

    logic        clk;
    logic        rst;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_we;
    logic [31:0] dmem_rdata;

    logic [31:0] prog [64];
    logic [31:0] dmem [64];
    logic [63:0] exp_stores [N_STORES];   // {address, data}
    int          store_idx;
    int          cycles;

    rv_core rv_core_inst (
        .clk        (clk),
        .rst        (rst),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    always #5 clk = ~clk;

    // fetches past the program see a nop
    assign imem_data  = (imem_addr < IMEM_BYTES) ? prog[imem_addr[7:2]] : NOP;
    assign dmem_rdata = dmem[dmem_addr[7:2]];

    always @(posedge clk)
    begin
        if (dmem_we)
            dmem[dmem_addr[7:2]] <= dmem_wdata;
    end

    always @(posedge clk)
    begin
        if (rst)
            cycles <= 0;
        else
            cycles <= cycles + 1;
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    // word store only
    function automatic logic [31:0] s_type(input logic [4:0] rs2, input logic [4:0] rs1,
                                           input logic [11:0] off);
        return {off[11:5], rs2, rs1, 3'b010, off[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(input logic [6:0] op, input logic [4:0] rd,
                                           input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("mismatch %s: got %h, expected %h (store %0d)", name, got, exp, store_idx);
            $display("=== FAIL ===");
            $fatal(1, "store check failed");
        end
    endtask

    initial
    begin
        clk       = 1'b0;
        rst       = 1'b1;
        store_idx = 0;
        for (int i = 0; i < 64; i++)
        begin
            prog[6'(i)] = NOP;
            dmem[6'(i)] = 32'hdada_0000 + i;
        end

        prog[0]  = i_type(OPC_IMM, 3'b000, 5'd1, 5'd0, 12'd5);        // addi x1, x0, 5
        prog[1]  = i_type(OPC_IMM, 3'b000, 5'd2, 5'd0, 12'hffd);      // addi x2, x0, -3
        prog[2]  = u_type(7'b0110111, 5'd3, 20'h80000);               // lui x3
        prog[3]  = u_type(7'b0010111, 5'd4, 20'h00001);               // auipc x4 at pc 0x0c
        prog[4]  = s_type(5'd4, 5'd0, 12'h000);
        prog[5]  = r_type(7'h20, 3'b000, 5'd5, 5'd1, 5'd2);           // sub
        prog[6]  = s_type(5'd5, 5'd0, 12'h004);
        prog[7]  = r_type(7'h00, 3'b100, 5'd6, 5'd1, 5'd2);           // xor
        prog[8]  = s_type(5'd6, 5'd0, 12'h008);
        prog[9]  = r_type(7'h00, 3'b110, 5'd7, 5'd5, 5'd1);           // or
        prog[10] = s_type(5'd7, 5'd0, 12'h00c);
        prog[11] = r_type(7'h00, 3'b111, 5'd8, 5'd6, 5'd3);           // and
        prog[12] = s_type(5'd8, 5'd0, 12'h010);
        prog[13] = r_type(7'h20, 3'b101, 5'd9, 5'd3, 5'd1);           // sra
        prog[14] = s_type(5'd9, 5'd0, 12'h014);
        prog[15] = r_type(7'h00, 3'b101, 5'd9, 5'd3, 5'd1);           // srl
        prog[16] = s_type(5'd9, 5'd0, 12'h018);
        prog[17] = r_type(7'h00, 3'b001, 5'd9, 5'd2, 5'd1);           // sll
        prog[18] = s_type(5'd9, 5'd0, 12'h01c);
        prog[19] = r_type(7'h00, 3'b010, 5'd10, 5'd2, 5'd1);          // slt, -3 < 5
        prog[20] = r_type(7'h00, 3'b011, 5'd11, 5'd2, 5'd1);          // sltu, big < 5
        prog[21] = r_type(7'h20, 3'b000, 5'd10, 5'd10, 5'd11);        // only 1 - 0 gives 1
        prog[22] = s_type(5'd10, 5'd0, 12'h020);
        prog[23] = i_type(OPC_IMM, 3'b110, 5'd12, 5'd1, 12'h0f0);     // ori
        prog[24] = i_type(OPC_IMM, 3'b111, 5'd12, 5'd12, 12'h0fc);    // andi
        prog[25] = i_type(OPC_IMM, 3'b001, 5'd12, 5'd12, 12'h004);    // slli 4
        prog[26] = i_type(OPC_IMM, 3'b100, 5'd12, 5'd12, 12'hfff);    // xori -1
        prog[27] = i_type(OPC_IMM, 3'b101, 5'd12, 5'd12, 12'h408);    // srai 8
        prog[28] = i_type(OPC_IMM, 3'b101, 5'd12, 5'd12, 12'h01c);    // srli 28
        prog[29] = s_type(5'd12, 5'd0, 12'h024);
        prog[30] = i_type(OPC_IMM, 3'b011, 5'd13, 5'd1, 12'hfff);     // sltiu
        prog[31] = i_type(OPC_IMM, 3'b010, 5'd14, 5'd1, 12'hfff);     // slti
        prog[32] = r_type(7'h20, 3'b000, 5'd13, 5'd13, 5'd14);
        prog[33] = s_type(5'd13, 5'd0, 12'h028);
        prog[34] = s_type(5'd2, 5'd0, 12'h02c);
        prog[35] = i_type(OPC_LOAD, 3'b010, 5'd15, 5'd0, 12'h004);    // lw x15, 4(x0)
        prog[36] = s_type(5'd15, 5'd0, 12'h030);
        prog[37] = i_type(OPC_IMM, 3'b000, 5'd0, 5'd0, 12'd7);        // write to x0
        prog[38] = s_type(5'd0, 5'd0, 12'h034);
        prog[39] = b_type(3'b000, 5'd1, 5'd5, 13'd8);                 // beq, not taken
        prog[40] = s_type(5'd1, 5'd0, 12'h038);
        prog[41] = b_type(3'b001, 5'd1, 5'd5, 13'd8);                 // bne, taken
        prog[42] = s_type(5'd2, 5'd0, 12'h038);
        prog[43] = b_type(3'b000, 5'd15, 5'd5, 13'd8);                // beq, taken
        prog[44] = s_type(5'd2, 5'd0, 12'h03c);
        prog[45] = b_type(3'b001, 5'd15, 5'd5, 13'd8);                // bne, not taken
        prog[46] = s_type(5'd3, 5'd0, 12'h03c);
        prog[47] = j_type(5'd16, 21'd8);                              // jal x16, +8
        prog[48] = s_type(5'd2, 5'd0, 12'h040);
        prog[49] = s_type(5'd16, 5'd0, 12'h040);
        prog[50] = i_type(OPC_JALR, 3'b000, 5'd17, 5'd16, 12'h010);   // to 0xd0
        prog[51] = s_type(5'd2, 5'd0, 12'h044);
        prog[52] = s_type(5'd17, 5'd0, 12'h044);
        prog[53] = j_type(5'd0, 21'd0);                               // park here

        exp_stores[0]  = {32'h0000_0000, 32'h0000_100c};
        exp_stores[1]  = {32'h0000_0004, 32'h0000_0008};
        exp_stores[2]  = {32'h0000_0008, 32'hffff_fff8};
        exp_stores[3]  = {32'h0000_000c, 32'h0000_000d};
        exp_stores[4]  = {32'h0000_0010, 32'h8000_0000};
        exp_stores[5]  = {32'h0000_0014, 32'hfc00_0000};
        exp_stores[6]  = {32'h0000_0018, 32'h0400_0000};
        exp_stores[7]  = {32'h0000_001c, 32'hffff_ffa0};
        exp_stores[8]  = {32'h0000_0020, 32'h0000_0001};
        exp_stores[9]  = {32'h0000_0024, 32'h0000_000f};
        exp_stores[10] = {32'h0000_0028, 32'h0000_0001};
        exp_stores[11] = {32'h0000_002c, 32'hffff_fffd};
        exp_stores[12] = {32'h0000_0030, 32'h0000_0008};
        exp_stores[13] = {32'h0000_0034, 32'h0000_0000};
        exp_stores[14] = {32'h0000_0038, 32'h0000_0005};
        exp_stores[15] = {32'h0000_003c, 32'h8000_0000};
        exp_stores[16] = {32'h0000_0040, 32'h0000_00c0};   // jal link
        exp_stores[17] = {32'h0000_0044, 32'h0000_00cc};   // jalr link

        repeat (2) @(negedge clk);
        rst = 1'b0;

        // every store cycle is matched against the next table entry
        while (store_idx < N_STORES && cycles < TIMEOUT)
        begin
            @(negedge clk);
            if (dmem_we)
            begin
                check_value("dmem_addr", dmem_addr, exp_stores[5'(store_idx)][63:32]);
                check_value("dmem_wdata", dmem_wdata, exp_stores[5'(store_idx)][31:0]);
                store_idx++;
            end
        end

        if (store_idx == N_STORES)
        begin
            // fetch should sit on the closing jump to itself
            repeat (2)
            begin
                @(negedge clk);
                check_value("imem_addr", imem_addr, PARK_PC);
            end
            $display("=== PASS ===");
            $finish;
        end
        else
        begin
            $display("timeout after %0d cycles, only %0d of %0d stores were seen",
                     cycles, store_idx, N_STORES);
            $display("=== FAIL ===");
            $fatal(1, "simulation timed out");
        end
    end

endmodule : tb_rv_core

`default_nettype wire
